//--- sim.f
+incdir+.
fetch_pkg.sv
mem_controller.sv
mem_arbiter.sv
icache.sv
fetch_unit.sv
fetch_top.sv
fetch_asserts.sv
tb_fetch.sv

//--- Makefile
# Verilator regression for the fetch subsystem
VERILATOR ?= verilator
TOP ?= tb_fetch
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal --timescale 1ns/100ps
FAIL_PATTERN ?= Regression failed
PASS_PATTERN ?= Regression passed

SOURCES := $(wildcard *.sv *.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "make help   show this list"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_PATTERN)" $(LOG); then echo "test failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_PATTERN)" $(LOG) || { echo "run ended without a result, see $(LOG)"; exit 1; }
	@echo "test finished without errors"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_fetch.sv
`include "fetch_macros.svh"

module tb_fetch;

  timeunit 1ns;
  timeprecision 100ps;

  import fetch_pkg::*;

  localparam int clk_period = 100;
  // two passes over the loop and then random jumps
  localparam int loop_len = 56;
  localparam int n_fetch = 2 * loop_len + 96;
  localparam int n_data = 12;
  // worst case for one block with ack delay, gapped beats and pipeline overhead
  localparam int fill_cycles = 3 + `BEATS_PER_BLOCK * 3 + 8;
  localparam int watchdog_cycles = 2 * (n_fetch + n_data) * fill_cycles + 40 * n_data + 20;
  localparam addr_t entry_addr = 64'h0000_0000_8000_0010;

  logic clk = 1'b0;
  logic reset;
  addr_t entry;
  logic redirect;
  addr_t redirect_target;
  logic data_req;
  addr_t data_addr;
  logic bus_reqack;
  logic bus_respcyc;
  bus_word_t bus_resp;
  bus_tag_t bus_resptag;
  instr_t instr;
  addr_t instr_pc;
  logic instr_valid;
  block_t data_block;
  logic data_done;
  logic bus_reqcyc;
  bus_word_t bus_req;
  bus_tag_t bus_reqtag;
  logic bus_respack;

  logic [31:0] salt;
  int error_count = 0;
  int check_count = 0;
  int bus_req_count = 0;
  int instr_seen = 0;
  int blocks_seen = 0;
  logic data_phase = 1'b0;
  addr_t exp_pcs[$];
  addr_t exp_blocks[$];

  fetch_top fetch_top_i (.*);

  always #(clk_period / 2) clk = ~clk;

  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  // memory contents are the address xor the salt
  function automatic instr_t ref_word(addr_t a);
    return a[31:0] ^ salt;
  endfunction

  function automatic block_t expected_block(addr_t base);
    block_t b;
    for (int i = 0; i < `BLOCK_BYTES / 4; i++) begin
      b[i*32 +: 32] = ref_word(base + addr_t'(4 * i));
    end
    return b;
  endfunction

  task automatic check_value(input logic [`BLOCK_BITS-1:0] actual,
                             input logic [`BLOCK_BITS-1:0] expected, input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("error at %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  initial begin : run_control
    void'($urandom(32'h3023_8ac2));
    salt = $urandom();
    reset = 1'b1;
    entry = entry_addr;
    redirect = 1'b0;
    redirect_target = '0;
    data_req = 1'b0;
    data_addr = '0;
    bus_reqack = 1'b0;
    bus_respcyc = 1'b0;
    bus_resp = '0;
    bus_resptag = '0;
    exp_pcs.push_back(entry_addr);
    repeat (10) next_cycle();
    reset = 1'b0;
    wait ((instr_seen >= n_fetch) && (blocks_seen >= n_data));
    repeat (4) next_cycle();
    $display("checks: %0d, errors: %0d, bus requests: %0d",
             check_count, error_count, bus_req_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(watchdog_cycles * clk_period);
    $display("timeout: fetch stream stalled after %0d instructions", instr_seen);
    $display("Regression failed");
    $finish;
  end

  // count accepted requests mid-cycle
  always @(negedge clk) begin
    if (!reset && bus_reqcyc && bus_reqack) begin
      bus_req_count++;
    end
  end

  initial begin : bus_memory
    addr_t base;
    int delay;
    int gap;
    wait (reset === 1'b0);
    forever begin
      next_cycle();
      if (bus_reqcyc) begin
        delay = $urandom_range(3);
        repeat (delay) next_cycle();
        base = bus_req;
        check_value(bus_reqtag, `BUS_TAG_READ, "bus_reqtag");
        bus_reqack = 1'b1;
        next_cycle();
        bus_reqack = 1'b0;
        // beat i carries words 2i and 2i+1
        for (int beat = 0; beat < `BEATS_PER_BLOCK; beat++) begin
          gap = $urandom_range(2);
          // some idle cycles carry a stray beat with a foreign tag
          repeat (gap) begin
            bus_resp = {$urandom(), $urandom()};
            bus_resptag = bus_tag_t'(`BUS_TAG_READ + 1);
            bus_respcyc = ($urandom_range(1) == 1);
            @(negedge clk);
            check_value(bus_respack, 1'b0, "bus_respack on a foreign tag");
            next_cycle();
          end
          bus_resp = {ref_word(base + addr_t'(8 * beat + 4)),
                      ref_word(base + addr_t'(8 * beat))};
          bus_resptag = `BUS_TAG_READ;
          bus_respcyc = 1'b1;
          @(negedge clk);
          check_value(bus_respack, 1'b1, "bus_respack on a read beat");
          next_cycle();
          bus_respcyc = 1'b0;
          bus_resptag = '0;
        end
      end
    end
  end

  initial begin : fetch_stimulus
    addr_t stim_pc;
    addr_t next_pc;
    int loop_reqs;
    int k;
    stim_pc = entry_addr;
    k = 0;
    wait (reset === 1'b0);
    forever begin
      next_cycle();
      redirect = 1'b0;
      if (instr_valid) begin
        next_pc = stim_pc + 4;
        if (k == loop_len - 1) begin
          // close the loop with every line of it now cached
          loop_reqs = bus_req_count;
          redirect = 1'b1;
          redirect_target = entry_addr;
          next_pc = entry_addr;
        end else if (k == 2 * loop_len - 1) begin
          check_value(bus_req_count - loop_reqs, 0, "bus requests on second loop pass");
          data_phase = 1'b1;
        end else if (k >= 2 * loop_len && $urandom_range(7) == 0) begin
          redirect = 1'b1;
          redirect_target = 64'h8000_0000 + addr_t'($urandom_range(4095)) * 4;
          next_pc = redirect_target;
        end
        exp_pcs.push_back(next_pc);
        stim_pc = next_pc;
        k++;
      end
    end
  end

  // data reads overlap the instruction fills of the random phase
  initial begin : data_stimulus
    addr_t a;
    int gap;
    wait (data_phase === 1'b1);
    for (int n = 0; n < n_data; n++) begin
      gap = $urandom_range(31);
      repeat (gap + 1) next_cycle();
      a = 64'h9000_0000 + addr_t'($urandom_range(1023)) * `BLOCK_BYTES;
      exp_blocks.push_back(a);
      data_addr = a;
      data_req = 1'b1;
      next_cycle();
      data_req = 1'b0;
      wait (blocks_seen > n);
    end
  end

  initial begin : compare
    addr_t pc_exp;
    addr_t blk_addr;
    forever begin
      @(negedge clk);
      if (instr_valid === 1'b1) begin
        if (exp_pcs.size() == 0) begin
          error_count++;
          $display("instruction strobe at %0d ns with no fetch expected", $time);
        end else begin
          pc_exp = exp_pcs.pop_front();
          check_value(instr_pc, pc_exp, "instr_pc");
          check_value(instr, ref_word(pc_exp), "instr");
        end
        instr_seen++;
      end
      if (data_done === 1'b1) begin
        if (exp_blocks.size() == 0) begin
          error_count++;
          $display("data_done at %0d ns with no data read issued", $time);
        end else begin
          blk_addr = exp_blocks.pop_front();
          check_value(data_block, expected_block(blk_addr), "data_block");
        end
        blocks_seen++;
      end
    end
  end

endmodule

//--- fetch_asserts.sv
module fetch_asserts (
  input logic clk,
  input logic reset,
  input logic bus_reqcyc,
  input logic bus_reqack,
  input logic bus_respcyc,
  input logic bus_respack,
  input logic instr_valid,
  input logic data_done
);

  timeunit 1ns;
  timeprecision 100ps;

  // request stays on the bus until it is accepted
  reqcyc_held: assert property (
    @(posedge clk) disable iff (reset) (bus_reqcyc && !bus_reqack) |=> bus_reqcyc
  ) else $error("bus_reqcyc dropped before bus_reqack");

  respack_with_respcyc: assert property (
    @(posedge clk) disable iff (reset) bus_respack |-> bus_respcyc
  ) else $error("bus_respack high without bus_respcyc");

  instr_valid_pulse: assert property (
    @(posedge clk) disable iff (reset) instr_valid |=> !instr_valid
  ) else $error("instr_valid lasted more than one cycle");

  data_done_pulse: assert property (
    @(posedge clk) disable iff (reset) data_done |=> !data_done
  ) else $error("data_done lasted more than one cycle");

  // checked mid-cycle, after the first reset edge has settled the strobe
  instr_valid_in_reset: assert property (
    @(negedge clk) reset |-> !instr_valid
  ) else $error("instr_valid high during reset");

endmodule

bind fetch_top fetch_asserts fetch_asserts_i (
  .clk(clk),
  .reset(reset),
  .bus_reqcyc(bus_reqcyc),
  .bus_reqack(bus_reqack),
  .bus_respcyc(bus_respcyc),
  .bus_respack(bus_respack),
  .instr_valid(instr_valid),
  .data_done(data_done)
);

//--- fetch_top.sv
`include "fetch_macros.svh"

module fetch_top (
  input  logic                 clk,
  input  logic                 reset,
  input  fetch_pkg::addr_t     entry,
  input  logic                 redirect,
  input  fetch_pkg::addr_t     redirect_target,
  input  logic                 data_req,
  input  fetch_pkg::addr_t     data_addr,
  input  logic                 bus_reqack,
  input  logic                 bus_respcyc,
  input  fetch_pkg::bus_word_t bus_resp,
  input  fetch_pkg::bus_tag_t  bus_resptag,
  output fetch_pkg::instr_t    instr,
  output fetch_pkg::addr_t     instr_pc,
  output logic                 instr_valid,
  output fetch_pkg::block_t    data_block,
  output logic                 data_done,
  output logic                 bus_reqcyc,
  output fetch_pkg::bus_word_t bus_req,
  output fetch_pkg::bus_tag_t  bus_reqtag,
  output logic                 bus_respack
);

  import fetch_pkg::*;

  // fetch unit to cache
  logic rd_req;
  addr_t rd_addr;
  logic rd_done;
  instr_t rd_instr;

  // cache to arbiter
  logic fill_req;
  addr_t fill_addr;
  logic fill_done;
  block_t fill_block;

  // arbiter to controller
  logic mem_start;
  addr_t mem_addr;
  block_t mem_block;
  logic mem_valid;

  fetch_unit fetch_unit_i (
    .clk(clk),
    .reset(reset),
    .entry(entry),
    .redirect(redirect),
    .redirect_target(redirect_target),
    .rd_done(rd_done),
    .rd_instr(rd_instr),
    .rd_req(rd_req),
    .rd_addr(rd_addr),
    .instr(instr),
    .instr_pc(instr_pc),
    .instr_valid(instr_valid)
  );

  icache icache_i (
    .clk(clk),
    .reset(reset),
    .rd_req(rd_req),
    .rd_addr(rd_addr),
    .fill_done(fill_done),
    .fill_block(fill_block),
    .rd_done(rd_done),
    .rd_instr(rd_instr),
    .fill_req(fill_req),
    .fill_addr(fill_addr)
  );

  mem_arbiter mem_arbiter_i (
    .clk(clk),
    .reset(reset),
    .data_req(data_req),
    .data_addr(data_addr),
    .icache_req(fill_req),
    .icache_addr(fill_addr),
    .mem_data(mem_block),
    .mem_valid(mem_valid),
    .data_block(data_block),
    .data_done(data_done),
    .icache_block(fill_block),
    .icache_done(fill_done),
    .mem_start(mem_start),
    .mem_addr(mem_addr)
  );

  mem_controller mem_controller_i (
    .clk(clk),
    .reset(reset),
    .start(mem_start),
    .addr(mem_addr),
    .bus_reqack(bus_reqack),
    .bus_respcyc(bus_respcyc),
    .bus_resp(bus_resp),
    .bus_resptag(bus_resptag),
    .block(mem_block),
    .valid(mem_valid),
    .bus_reqcyc(bus_reqcyc),
    .bus_req(bus_req),
    .bus_reqtag(bus_reqtag),
    .bus_respack(bus_respack)
  );

endmodule

//--- fetch_unit.sv
`include "fetch_macros.svh"

module fetch_unit (
  input  logic              clk,
  input  logic              reset,
  input  fetch_pkg::addr_t  entry,
  input  logic              redirect,
  input  fetch_pkg::addr_t  redirect_target,
  input  logic              rd_done,
  input  fetch_pkg::instr_t rd_instr,
  output logic              rd_req,
  output fetch_pkg::addr_t  rd_addr,
  output fetch_pkg::instr_t instr,
  output fetch_pkg::addr_t  instr_pc,
  output logic              instr_valid
);

  import fetch_pkg::*;

  addr_t pc;
  logic waiting;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= entry;
      // first fetch leaves as soon as reset drops
      rd_req <= 1'b1;
      waiting <= 1'b0;
      instr_valid <= 1'b0;
    end else begin
      rd_req <= instr_valid;
      instr_valid <= waiting && rd_done;
      if (rd_req) begin
        waiting <= 1'b1;
      end else if (rd_done) begin
        waiting <= 1'b0;
      end
      // redirect is sampled alongside the instruction strobe
      if (instr_valid) begin
        pc <= redirect ? redirect_target : instr_pc + addr_t'(`INSTR_BITS / 8);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (waiting && rd_done) begin
      instr <= rd_instr;
      instr_pc <= pc;
    end
  end

  assign rd_addr = pc;

endmodule

//--- icache.sv
`include "fetch_macros.svh"

module icache (
  input  logic              clk,
  input  logic              reset,
  input  logic              rd_req,
  input  fetch_pkg::addr_t  rd_addr,
  input  logic              fill_done,
  input  fetch_pkg::block_t fill_block,
  output logic              rd_done,
  output fetch_pkg::instr_t rd_instr,
  output logic              fill_req,
  output fetch_pkg::addr_t  fill_addr
);

  import fetch_pkg::*;

  localparam int offset_bits = $clog2(`BLOCK_BYTES);
  localparam int index_bits = $clog2(`ICACHE_LINES);
  localparam int tag_bits = `ADDR_BITS - offset_bits - index_bits;
  localparam int word_bits = $clog2(`BLOCK_BYTES / (`INSTR_BITS / 8));

  cache_state_t state;
  addr_t req_addr;
  logic [tag_bits-1:0] tag_mem [`ICACHE_LINES];
  block_t data_mem [`ICACHE_LINES];
  logic [`ICACHE_LINES-1:0] valid_bits;
  logic [index_bits-1:0] index;
  logic [tag_bits-1:0] tag;
  logic [word_bits-1:0] word_sel;
  logic hit;
  instr_t word_q;
  logic fill_req_q;

  // 32-bit word out of a line, word 0 in the low bits
  function automatic instr_t pick_word(block_t line, logic [word_bits-1:0] sel);
    pick_word = line[sel*`INSTR_BITS +: `INSTR_BITS];
  endfunction

  // offset below, index in the middle, tag on top
  assign index = req_addr[offset_bits +: index_bits];
  assign tag = req_addr[`ADDR_BITS-1 -: tag_bits];
  assign word_sel = req_addr[offset_bits-1 -: word_bits];
  assign hit = valid_bits[index] && (tag_mem[index] == tag);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cache_idle;
      valid_bits <= '0;
      fill_req_q <= 1'b0;
    end else begin
      fill_req_q <= 1'b0;
      case (state)
        cache_idle: begin
          if (rd_req) begin
            state <= cache_lookup;
          end
        end
        cache_lookup: begin
          if (hit) begin
            state <= cache_respond;
          end else begin
            // miss, ask for the whole line
            state <= cache_fill_wait;
            fill_req_q <= 1'b1;
          end
        end
        cache_fill_wait: begin
          if (fill_done) begin
            valid_bits[index] <= 1'b1;
            state <= cache_respond;
          end
        end
        cache_respond: begin
          state <= cache_idle;
        end
        default: begin
          state <= cache_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == cache_idle) && rd_req) begin
      req_addr <= rd_addr;
    end
    if ((state == cache_lookup) && hit) begin
      word_q <= pick_word(data_mem[index], word_sel);
    end
    // line write and word pick in the same cycle
    if ((state == cache_fill_wait) && fill_done) begin
      tag_mem[index] <= tag;
      data_mem[index] <= fill_block;
      word_q <= pick_word(fill_block, word_sel);
    end
  end

  assign rd_done = (state == cache_respond);
  assign rd_instr = word_q;
  assign fill_req = fill_req_q;
  assign fill_addr = {req_addr[`ADDR_BITS-1:offset_bits], {offset_bits{1'b0}}};

endmodule

//--- mem_arbiter.sv
`include "fetch_macros.svh"

module mem_arbiter (
  input  logic              clk,
  input  logic              reset,
  input  logic              data_req,
  input  fetch_pkg::addr_t  data_addr,
  input  logic              icache_req,
  input  fetch_pkg::addr_t  icache_addr,
  input  fetch_pkg::block_t mem_data,
  input  logic              mem_valid,
  output fetch_pkg::block_t data_block,
  output logic              data_done,
  output fetch_pkg::block_t icache_block,
  output logic              icache_done,
  output logic              mem_start,
  output fetch_pkg::addr_t  mem_addr
);

  import fetch_pkg::*;

  grant_t grant;
  logic data_pend;
  logic inst_pend;
  addr_t data_addr_q;
  addr_t inst_addr_q;
  addr_t mem_addr_q;
  logic want_data;
  logic want_inst;

  // a request pulse in this cycle counts as pending too
  assign want_data = data_req || data_pend;
  assign want_inst = icache_req || inst_pend;

  always_ff @(posedge clk) begin
    if (reset) begin
      grant <= grant_none;
      data_pend <= 1'b0;
      inst_pend <= 1'b0;
      mem_start <= 1'b0;
    end else begin
      mem_start <= 1'b0;
      if (data_req) begin
        data_pend <= 1'b1;
      end
      if (icache_req) begin
        inst_pend <= 1'b1;
      end
      case (grant)
        grant_none: begin
          // data port wins when both wait
          if (want_data) begin
            grant <= grant_data;
            data_pend <= 1'b0;
            mem_start <= 1'b1;
          end else if (want_inst) begin
            grant <= grant_inst;
            inst_pend <= 1'b0;
            mem_start <= 1'b1;
          end
        end
        default: begin
          if (mem_valid) begin
            grant <= grant_none;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (data_req) begin
      data_addr_q <= data_addr;
    end
    if (icache_req) begin
      inst_addr_q <= icache_addr;
    end
    if (grant == grant_none) begin
      if (want_data) begin
        mem_addr_q <= data_req ? data_addr : data_addr_q;
      end else if (want_inst) begin
        mem_addr_q <= icache_req ? icache_addr : inst_addr_q;
      end
    end
  end

  assign mem_addr = mem_addr_q;

  // completion goes back to the owner only
  assign data_done = mem_valid && (grant == grant_data);
  assign icache_done = mem_valid && (grant == grant_inst);
  assign data_block = (grant == grant_data) ? mem_data : '0;
  assign icache_block = (grant == grant_inst) ? mem_data : '0;

endmodule

//--- mem_controller.sv
`include "fetch_macros.svh"

module mem_controller (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  fetch_pkg::addr_t     addr,
  input  logic                 bus_reqack,
  input  logic                 bus_respcyc,
  input  fetch_pkg::bus_word_t bus_resp,
  input  fetch_pkg::bus_tag_t  bus_resptag,
  output fetch_pkg::block_t    block,
  output logic                 valid,
  output logic                 bus_reqcyc,
  output fetch_pkg::bus_word_t bus_req,
  output fetch_pkg::bus_tag_t  bus_reqtag,
  output logic                 bus_respack
);

  import fetch_pkg::*;

  localparam int beat_cnt_bits = $clog2(`BEATS_PER_BLOCK);

  ctrl_state_t state;
  addr_t req_addr;
  block_t block_q;
  logic [beat_cnt_bits-1:0] beat_cnt;
  logic beat_take;
  logic last_beat;

  // a beat counts only if it carries our read tag
  assign beat_take = (state == ctrl_receive) && bus_respcyc &&
                     (bus_resptag == `BUS_TAG_READ);
  assign last_beat = (beat_cnt == beat_cnt_bits'(`BEATS_PER_BLOCK - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ctrl_idle;
      beat_cnt <= '0;
    end else begin
      case (state)
        ctrl_idle: begin
          if (start) begin
            state <= ctrl_request;
            beat_cnt <= '0;
          end
        end
        ctrl_request: begin
          // request stays on the bus until it is accepted
          if (bus_reqack) begin
            state <= ctrl_receive;
          end
        end
        ctrl_receive: begin
          if (beat_take) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (last_beat) begin
              state <= ctrl_done;
            end
          end
        end
        ctrl_done: begin
          state <= ctrl_idle;
        end
        default: begin
          state <= ctrl_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == ctrl_idle) && start) begin
      req_addr <= addr;
    end
    // beats arrive in ascending word order, so shift in from the top
    if (beat_take) begin
      block_q <= {bus_resp, block_q[`BLOCK_BITS-1:`BUS_DATA_BITS]};
    end
  end

  assign bus_reqcyc = (state == ctrl_request);
  assign bus_req = req_addr;
  assign bus_reqtag = `BUS_TAG_READ;
  assign bus_respack = beat_take;

  // one-cycle strobe after the last beat
  assign valid = (state == ctrl_done);
  assign block = block_q;

endmodule

//--- fetch_pkg.sv
`include "fetch_macros.svh"

package fetch_pkg;

  // byte address, also sent as the bus request word
  typedef logic [`ADDR_BITS-1:0] addr_t;
  typedef logic [`INSTR_BITS-1:0] instr_t;
  // cache line with word 0 in the low bits
  typedef logic [`BLOCK_BITS-1:0] block_t;
  typedef logic [`BUS_DATA_BITS-1:0] bus_word_t;
  typedef logic [`BUS_TAG_BITS-1:0] bus_tag_t;

  typedef enum logic [1:0] {
    ctrl_idle,
    ctrl_request,
    ctrl_receive,
    ctrl_done
  } ctrl_state_t;

  typedef enum logic [1:0] {
    cache_idle,
    cache_lookup,
    cache_fill_wait,
    cache_respond
  } cache_state_t;

  // owner of the memory controller
  typedef enum logic [1:0] {
    grant_none,
    grant_data,
    grant_inst
  } grant_t;

endpackage

//--- fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// address and instruction widths
`define ADDR_BITS 64
`define INSTR_BITS 32

// system bus beat and tag widths
`define BUS_DATA_BITS 64
`define BUS_TAG_BITS 13

// one memory block is a full cache line
`define BLOCK_BYTES 64
`define BLOCK_BITS 512
`define BEATS_PER_BLOCK 8

// direct-mapped instruction cache depth
`define ICACHE_LINES 16

// read request to memory, echoed back on every response beat
`define BUS_TAG_READ 13'h1100

`endif
